//--- logic/soc_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus subsystem definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package soc_bus_pkg;

    localparam int MemAddrBus = 32;  // address width
    localparam int MemBus     = 32;  // data width

    localparam logic HoldEnable  = 1'b1;
    localparam logic HoldDisable = 1'b0;

    localparam logic [MemBus-1:0] INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

    // top nibble of the address picks the slave
    localparam logic [3:0] RegionRam   = 4'h0;
    localparam logic [3:0] RegionGpio  = 4'h1;
    localparam logic [3:0] RegionTimer = 4'h2;
    localparam logic [3:0] RegionWait  = 4'h3;

    localparam int WordIdxW = MemAddrBus - 6;  // offset bits above bit 1

    localparam int RamDepthLog2  = 8;
    localparam int WaitDepthLog2 = 4;
    localparam int WaitCycles    = 3;
    localparam int GpioWidth     = 8;

    localparam logic [WordIdxW-1:0] GpioOffOut = WordIdxW'(0);
    localparam logic [WordIdxW-1:0] GpioOffDir = WordIdxW'(1);
    localparam logic [WordIdxW-1:0] GpioOffPin = WordIdxW'(2);

    localparam logic [WordIdxW-1:0] TimerOffCtrl  = WordIdxW'(0);
    localparam logic [WordIdxW-1:0] TimerOffValue = WordIdxW'(1);
    localparam logic [WordIdxW-1:0] TimerOffCmp   = WordIdxW'(2);

    typedef union packed {
        logic [MemAddrBus-1:0] raw;
        struct packed {
            logic [3:0]            region;
            logic [MemAddrBus-5:0] offset;
        } fields;
    } bus_addr_u;

endpackage

//--- logic/rib.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus arbiter and decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rib (
    input  logic [soc_bus_pkg::MemAddrBus-1:0] m0_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m0_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m0_data_o,
    input  logic                               m0_req_i,
    input  logic                               m0_we_i,
    output logic                               m0_ready_o,

    input  logic [soc_bus_pkg::MemAddrBus-1:0] m1_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m1_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m1_data_o,
    input  logic                               m1_req_i,
    input  logic                               m1_we_i,
    output logic                               m1_ready_o,

    input  logic [soc_bus_pkg::MemAddrBus-1:0] m2_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m2_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m2_data_o,
    input  logic                               m2_req_i,
    input  logic                               m2_we_i,

    input  logic [soc_bus_pkg::MemAddrBus-1:0] m3_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m3_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m3_data_o,
    input  logic                               m3_req_i,
    input  logic                               m3_we_i,

    output logic [soc_bus_pkg::MemAddrBus-1:0] s0_addr_o,
    output logic [    soc_bus_pkg::MemBus-1:0] s0_data_o,
    input  logic [    soc_bus_pkg::MemBus-1:0] s0_data_i,
    output logic                               s0_we_o,

    output logic [soc_bus_pkg::MemAddrBus-1:0] s1_addr_o,
    output logic [    soc_bus_pkg::MemBus-1:0] s1_data_o,
    input  logic [    soc_bus_pkg::MemBus-1:0] s1_data_i,
    output logic                               s1_we_o,

    output logic [soc_bus_pkg::MemAddrBus-1:0] s2_addr_o,
    output logic [    soc_bus_pkg::MemBus-1:0] s2_data_o,
    input  logic [    soc_bus_pkg::MemBus-1:0] s2_data_i,
    output logic                               s2_we_o,

    output logic [soc_bus_pkg::MemAddrBus-1:0] s3_addr_o,
    output logic [    soc_bus_pkg::MemBus-1:0] s3_data_o,
    input  logic [    soc_bus_pkg::MemBus-1:0] s3_data_i,
    output logic                               s3_we_o,
    output logic                               s3_req_o,
    input  logic                               s3_ready_i,

    output logic                               hold_flag_o
);
    import soc_bus_pkg::*;

    bus_addr_u         own_addr;   // address of the granted master
    logic [MemBus-1:0] own_wdata;
    logic              own_we;
    logic [MemBus-1:0] slv_rdata;  // read data of the selected slave
    logic              slv_ready;
    logic              req_any;

    assign req_any     = m0_req_i | m1_req_i | m2_req_i | m3_req_i;
    assign hold_flag_o = (m3_req_i | m0_req_i | m2_req_i) ? HoldEnable : HoldDisable;

    // fixed priority m3 > m0 > m2 > m1, m1 owns the bus when idle
    always_comb begin
        m0_data_o  = '0;
        m1_data_o  = INST_NOP;  // fetch stalls on a nop
        m2_data_o  = '0;
        m3_data_o  = '0;
        m0_ready_o = 1'b0;
        m1_ready_o = 1'b0;
        if (m3_req_i) begin
            own_addr  = m3_addr_i;
            own_wdata = m3_data_i;
            own_we    = m3_we_i;
            m3_data_o = slv_rdata;
        end else if (m0_req_i) begin
            own_addr   = m0_addr_i;
            own_wdata  = m0_data_i;
            own_we     = m0_we_i;
            m0_data_o  = slv_rdata;
            m0_ready_o = slv_ready;
        end else if (m2_req_i) begin
            own_addr  = m2_addr_i;
            own_wdata = m2_data_i;
            own_we    = m2_we_i;
            m2_data_o = slv_rdata;
        end else begin
            own_addr   = m1_addr_i;
            own_wdata  = m1_data_i;
            own_we     = m1_we_i;
            m1_data_o  = slv_rdata;
            m1_ready_o = slv_ready;
        end
    end

    // route the granted access by region
    always_comb begin
        s0_addr_o = '0;
        s1_addr_o = '0;
        s2_addr_o = '0;
        s3_addr_o = '0;
        s0_data_o = '0;
        s1_data_o = '0;
        s2_data_o = '0;
        s3_data_o = '0;
        s0_we_o   = 1'b0;
        s1_we_o   = 1'b0;
        s2_we_o   = 1'b0;
        s3_we_o   = 1'b0;
        s3_req_o  = 1'b0;
        slv_rdata = '0;   // unmapped reads as zero
        slv_ready = 1'b1; // and never stalls
        unique case (own_addr.fields.region)
            RegionRam: begin
                s0_addr_o = own_addr.raw;
                s0_data_o = own_wdata;
                s0_we_o   = own_we;
                slv_rdata = s0_data_i;
            end
            RegionGpio: begin
                s1_addr_o = own_addr.raw;
                s1_data_o = own_wdata;
                s1_we_o   = own_we;
                slv_rdata = s1_data_i;
            end
            RegionTimer: begin
                s2_addr_o = own_addr.raw;
                s2_data_o = own_wdata;
                s2_we_o   = own_we;
                slv_rdata = s2_data_i;
            end
            RegionWait: begin
                s3_addr_o = own_addr.raw;
                s3_data_o = own_wdata;
                s3_we_o   = own_we;
                s3_req_o  = req_any;
                slv_rdata = s3_data_i;
                slv_ready = s3_ready_i;  // only stalling slave
            end
            default: begin
            end
        endcase
    end

endmodule

//--- logic/data_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-cycle data RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module data_ram (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [soc_bus_pkg::MemAddrBus-1:0] addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] data_i,
    input  logic                               we_i,
    output logic [    soc_bus_pkg::MemBus-1:0] data_o
);
    import soc_bus_pkg::*;

    bus_addr_u               addr;
    logic [WordIdxW-1:0]     word_idx;
    logic [RamDepthLog2-1:0] ram_idx;
    logic [MemBus-1:0]       mem [2**RamDepthLog2];

    assign addr     = addr_i;
    assign word_idx = addr.fields.offset[2 +: WordIdxW];
    assign ram_idx  = word_idx[RamDepthLog2-1:0];  // upper index bits alias

    assign data_o = mem[ram_idx];

    always_ff @(posedge clk_i) begin
        if (we_i && arst_n_i) begin  // no writes held in reset
            mem[ram_idx] <= data_i;
        end
    end

endmodule

//--- logic/gpio_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module gpio_regs (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [soc_bus_pkg::MemAddrBus-1:0] addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] data_i,
    input  logic                               we_i,
    output logic [    soc_bus_pkg::MemBus-1:0] data_o,
    input  logic [ soc_bus_pkg::GpioWidth-1:0] gpio_i,
    output logic [ soc_bus_pkg::GpioWidth-1:0] gpio_o
);
    import soc_bus_pkg::*;

    bus_addr_u            addr;
    logic [WordIdxW-1:0]  word_idx;
    logic [GpioWidth-1:0] out_q;
    logic [GpioWidth-1:0] dir_q;  // 1 drives the pin
    logic [GpioWidth-1:0] pin_val;

    assign addr     = addr_i;
    assign word_idx = addr.fields.offset[2 +: WordIdxW];

    assign gpio_o  = out_q & dir_q;
    assign pin_val = (out_q & dir_q) | (gpio_i & ~dir_q);

    always_comb begin
        data_o = '0;
        unique case (word_idx)
            GpioOffOut: data_o = {{(MemBus-GpioWidth){1'b0}}, out_q};
            GpioOffDir: data_o = {{(MemBus-GpioWidth){1'b0}}, dir_q};
            GpioOffPin: data_o = {{(MemBus-GpioWidth){1'b0}}, pin_val};
            default:    data_o = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (we_i) begin
            if (word_idx == GpioOffOut) begin
                out_q <= data_i[GpioWidth-1:0];
            end
            if (word_idx == GpioOffDir) begin
                dir_q <= data_i[GpioWidth-1:0];
            end
        end
    end

endmodule

//--- logic/machine_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module machine_timer (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [soc_bus_pkg::MemAddrBus-1:0] addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] data_i,
    input  logic                               we_i,
    output logic [    soc_bus_pkg::MemBus-1:0] data_o,
    output logic                               irq_o
);
    import soc_bus_pkg::*;

    bus_addr_u           addr;
    logic [WordIdxW-1:0] word_idx;
    logic                wr_ctrl;
    logic                wr_value;
    logic                wr_cmp;
    logic                en_q;     // ctrl bit 0
    logic [MemBus-1:0]   value_q;
    logic [MemBus-1:0]   cmp_q;

    assign addr     = addr_i;
    assign word_idx = addr.fields.offset[2 +: WordIdxW];

    assign wr_ctrl  = we_i && (word_idx == TimerOffCtrl);
    assign wr_value = we_i && (word_idx == TimerOffValue);
    assign wr_cmp   = we_i && (word_idx == TimerOffCmp);

    assign irq_o = en_q && (value_q >= cmp_q);

    always_comb begin
        unique case (word_idx)
            TimerOffCtrl:  data_o = {{(MemBus-1){1'b0}}, en_q};
            TimerOffValue: data_o = value_q;
            TimerOffCmp:   data_o = cmp_q;
            default:       data_o = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q    <= 1'b0;
            value_q <= '0;
            cmp_q   <= '0;
        end else begin
            if (wr_ctrl) begin
                en_q <= data_i[0];
            end
            if (wr_cmp) begin
                cmp_q <= data_i;
            end
            if (wr_ctrl) begin
                value_q <= '0;  // restart count
            end else if (wr_value) begin
                value_q <= data_i;
            end else if (en_q) begin
                value_q <= value_q + 1'b1;
            end
        end
    end

endmodule

//--- logic/wait_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wait-state RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module wait_ram (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [soc_bus_pkg::MemAddrBus-1:0] addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] data_i,
    input  logic                               we_i,
    input  logic                               req_i,
    output logic [    soc_bus_pkg::MemBus-1:0] data_o,
    output logic                               ready_o
);
    import soc_bus_pkg::*;

    localparam int CntW = $clog2(WaitCycles + 1);
    localparam logic [CntW-1:0] CntLast = CntW'(WaitCycles);

    bus_addr_u                addr;
    logic [WordIdxW-1:0]      word_idx;
    logic [WaitDepthLog2-1:0] ram_idx;
    logic [MemBus-1:0]        mem [2**WaitDepthLog2];
    logic [CntW-1:0]          cnt_q;   // cycles of the pending access
    logic                     ready_q;

    assign addr     = addr_i;
    assign word_idx = addr.fields.offset[2 +: WordIdxW];
    assign ram_idx  = word_idx[WaitDepthLog2-1:0];

    assign ready_o = ready_q;
    assign data_o  = ready_q ? mem[ram_idx] : '0;  // valid only with ready

    // ready lands one cycle after the count reaches WaitCycles
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else if (ready_q) begin
            cnt_q   <= '0;  // one-cycle pulse, then idle
            ready_q <= 1'b0;
        end else if (req_i) begin
            if (cnt_q == CntLast) begin
                cnt_q   <= '0;
                ready_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else begin
            cnt_q <= '0;  // request dropped
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_q && req_i && we_i) begin
            mem[ram_idx] <= data_i;
        end
    end

endmodule

//--- logic/soc_bus_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus subsystem top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module soc_bus_top (
    input  logic                               clk_i,
    input  logic                               arst_n_i,

    input  logic [soc_bus_pkg::MemAddrBus-1:0] m0_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m0_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m0_data_o,
    input  logic                               m0_req_i,
    input  logic                               m0_we_i,
    output logic                               m0_ready_o,

    input  logic [soc_bus_pkg::MemAddrBus-1:0] m1_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m1_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m1_data_o,
    input  logic                               m1_req_i,
    input  logic                               m1_we_i,
    output logic                               m1_ready_o,

    input  logic [soc_bus_pkg::MemAddrBus-1:0] m2_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m2_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m2_data_o,
    input  logic                               m2_req_i,
    input  logic                               m2_we_i,

    input  logic [soc_bus_pkg::MemAddrBus-1:0] m3_addr_i,
    input  logic [    soc_bus_pkg::MemBus-1:0] m3_data_i,
    output logic [    soc_bus_pkg::MemBus-1:0] m3_data_o,
    input  logic                               m3_req_i,
    input  logic                               m3_we_i,

    input  logic [ soc_bus_pkg::GpioWidth-1:0] gpio_i,
    output logic [ soc_bus_pkg::GpioWidth-1:0] gpio_o,
    output logic                               timer_irq_o,
    output logic                               hold_flag_o
);
    import soc_bus_pkg::*;

    logic [MemAddrBus-1:0] s0_addr, s1_addr, s2_addr, s3_addr;
    logic [MemBus-1:0]     s0_wdata, s1_wdata, s2_wdata, s3_wdata;
    logic [MemBus-1:0]     s0_rdata, s1_rdata, s2_rdata, s3_rdata;
    logic                  s0_we, s1_we, s2_we, s3_we;
    logic                  s3_req, s3_ready;

    rib u_rib (
        .m0_addr_i  (m0_addr_i),  .m0_data_i (m0_data_i), .m0_data_o (m0_data_o),
        .m0_req_i   (m0_req_i),   .m0_we_i   (m0_we_i),   .m0_ready_o(m0_ready_o),
        .m1_addr_i  (m1_addr_i),  .m1_data_i (m1_data_i), .m1_data_o (m1_data_o),
        .m1_req_i   (m1_req_i),   .m1_we_i   (m1_we_i),   .m1_ready_o(m1_ready_o),
        .m2_addr_i  (m2_addr_i),  .m2_data_i (m2_data_i), .m2_data_o (m2_data_o),
        .m2_req_i   (m2_req_i),   .m2_we_i   (m2_we_i),
        .m3_addr_i  (m3_addr_i),  .m3_data_i (m3_data_i), .m3_data_o (m3_data_o),
        .m3_req_i   (m3_req_i),   .m3_we_i   (m3_we_i),
        .s0_addr_o  (s0_addr),    .s0_data_o (s0_wdata),  .s0_data_i (s0_rdata),
        .s0_we_o    (s0_we),
        .s1_addr_o  (s1_addr),    .s1_data_o (s1_wdata),  .s1_data_i (s1_rdata),
        .s1_we_o    (s1_we),
        .s2_addr_o  (s2_addr),    .s2_data_o (s2_wdata),  .s2_data_i (s2_rdata),
        .s2_we_o    (s2_we),
        .s3_addr_o  (s3_addr),    .s3_data_o (s3_wdata),  .s3_data_i (s3_rdata),
        .s3_we_o    (s3_we),      .s3_req_o  (s3_req),    .s3_ready_i(s3_ready),
        .hold_flag_o(hold_flag_o)
    );

    data_ram u_data_ram (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .addr_i  (s0_addr),
        .data_i  (s0_wdata),
        .we_i    (s0_we),
        .data_o  (s0_rdata)
    );

    gpio_regs u_gpio_regs (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .addr_i  (s1_addr),
        .data_i  (s1_wdata),
        .we_i    (s1_we),
        .data_o  (s1_rdata),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o)
    );

    machine_timer u_machine_timer (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .addr_i  (s2_addr),
        .data_i  (s2_wdata),
        .we_i    (s2_we),
        .data_o  (s2_rdata),
        .irq_o   (timer_irq_o)
    );

    wait_ram u_wait_ram (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .addr_i  (s3_addr),
        .data_i  (s3_wdata),
        .we_i    (s3_we),
        .req_i   (s3_req),
        .data_o  (s3_rdata),
        .ready_o (s3_ready)
    );

endmodule

//--- verification/soc_bus_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus subsystem testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module soc_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_bus_pkg::*;

    localparam int NumRam         = 16;
    localparam int NumGpio        = 6;
    localparam int NumWait        = 8;
    localparam int NumAccesses    = 2 * NumRam + 5 * NumGpio + 2 * NumWait + 24;
    localparam int WatchdogCycles = NumAccesses * (WaitCycles + 4) + 2000;

    logic                  clk_i = 1'b0;
    logic                  arst_n_i;
    logic [MemAddrBus-1:0] m0_addr_i, m1_addr_i, m2_addr_i, m3_addr_i;
    logic [MemBus-1:0]     m0_data_i, m1_data_i, m2_data_i, m3_data_i;
    logic [MemBus-1:0]     m0_data_o, m1_data_o, m2_data_o, m3_data_o;
    logic                  m0_req_i, m1_req_i, m2_req_i, m3_req_i;
    logic                  m0_we_i, m1_we_i, m2_we_i, m3_we_i;
    logic                  m0_ready_o, m1_ready_o;
    logic [GpioWidth-1:0]  gpio_i, gpio_o;
    logic                  timer_irq_o, hold_flag_o;

    logic [MemBus-1:0]    ram_m [2**RamDepthLog2];    // data RAM copy
    logic [MemBus-1:0]    wait_m [2**WaitDepthLog2];  // wait RAM copy
    logic [GpioWidth-1:0] out_m, dir_m;
    logic                 en_m;
    logic [MemBus-1:0]    value_m, cmp_m;

    soc_bus_top DUT (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [MemAddrBus-1:0] make_addr(logic [3:0] region, int word);
        return {region, word[25:0], 2'b00};
    endfunction

    // expected read word from the register and memory copies
    function automatic logic [MemBus-1:0] expected_read(logic [3:0] region, int word,
                                                        logic [GpioWidth-1:0] pins);
        logic [GpioWidth-1:0] mixed;
        mixed = (out_m & dir_m) | (pins & ~dir_m);  // driven bits read back the output
        case (region)
            RegionRam:   return ram_m[word % (2**RamDepthLog2)];
            RegionGpio:  return (word == GpioOffOut) ? MemBus'(out_m) :
                                (word == GpioOffDir) ? MemBus'(dir_m) :
                                (word == GpioOffPin) ? MemBus'(mixed) : '0;
            RegionTimer: return (word == TimerOffCtrl)  ? MemBus'(en_m) :
                                (word == TimerOffValue) ? value_m :
                                (word == TimerOffCmp)   ? cmp_m : '0;
            RegionWait:  return wait_m[word % (2**WaitDepthLog2)];
            default:     return '0;  // unmapped
        endcase
    endfunction

    task automatic check_word(string name, logic [MemBus-1:0] exp, logic [MemBus-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic m0_access(string name, logic [MemAddrBus-1:0] addr, logic we,
                             logic [MemBus-1:0] wdata, output logic [MemBus-1:0] rdata,
                             output int lat);
        @(posedge clk_i);
        m0_addr_i <= addr;
        m0_data_i <= wdata;
        m0_we_i   <= we;
        m0_req_i  <= 1'b1;
        lat = 0;
        @(negedge clk_i);
        while (!m0_ready_o && lat < 4 * WaitCycles + 8) begin  // stall on region 3
            lat++;
            @(negedge clk_i);
        end
        check_flag({name, " ready"}, 1'b1, m0_ready_o);
        check_flag({name, " hold"}, HoldEnable, hold_flag_o);
        rdata = m0_data_o;
        @(posedge clk_i);  // write lands here
        m0_req_i <= 1'b0;
        m0_we_i  <= 1'b0;
    endtask

    task automatic m0_write(string name, logic [3:0] region, int word, logic [MemBus-1:0] wdata);
        logic [MemBus-1:0] rdata;
        int                lat;
        m0_access(name, make_addr(region, word), 1'b1, wdata, rdata, lat);
        check_word({name, " latency"}, MemBus'((region == RegionWait) ? WaitCycles + 1 : 0),
                   MemBus'(lat));
    endtask

    task automatic m0_read(string name, logic [3:0] region, int word);
        logic [MemBus-1:0] rdata;
        int                lat;
        m0_access(name, make_addr(region, word), 1'b0, '0, rdata, lat);
        check_word({name, " latency"}, MemBus'((region == RegionWait) ? WaitCycles + 1 : 0),
                   MemBus'(lat));
        check_word(name, expected_read(region, word, gpio_i), rdata);
    endtask

    task automatic m1_read(string name, int word);
        @(posedge clk_i);
        m1_addr_i <= make_addr(RegionRam, word);
        m1_req_i  <= 1'b1;
        @(negedge clk_i);
        check_flag({name, " ready"}, 1'b1, m1_ready_o);
        check_flag({name, " hold"}, HoldDisable, hold_flag_o);  // fetch alone never holds
        check_word(name, expected_read(RegionRam, word, gpio_i), m1_data_o);
        @(posedge clk_i);
        m1_req_i <= 1'b0;
    endtask

    // debug port has no ready, done in one cycle
    task automatic m2_write(logic [MemAddrBus-1:0] addr, logic [MemBus-1:0] wdata);
        @(posedge clk_i);
        m2_addr_i <= addr;
        m2_data_i <= wdata;
        m2_we_i   <= 1'b1;
        m2_req_i  <= 1'b1;
        @(negedge clk_i);
        check_flag("m2 write hold", HoldEnable, hold_flag_o);
        @(posedge clk_i);
        m2_req_i <= 1'b0;
        m2_we_i  <= 1'b0;
    endtask

    // pins always follow the out and dir copies
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            check_word("gpio_o", MemBus'(out_m & dir_m), MemBus'(gpio_o));
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk_i);
        $display("timeout after %0d cycles, the bus stopped answering", WatchdogCycles);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int                word;
        int                c_val;
        int                cycles;
        logic [MemBus-1:0] data;
        int                ram_words[$];
        int                wait_words[$];
        void'($urandom(87));
        arst_n_i   = 1'b0;
        {m0_addr_i, m1_addr_i, m2_addr_i, m3_addr_i} = '0;
        {m0_data_i, m1_data_i, m2_data_i, m3_data_i} = '0;
        {m0_req_i, m1_req_i, m2_req_i, m3_req_i}     = '0;
        {m0_we_i, m1_we_i, m2_we_i, m3_we_i}         = '0;
        gpio_i  = '0;
        out_m   = '0;
        dir_m   = '0;
        en_m    = 1'b0;
        value_m = '0;
        cmp_m   = '0;
        repeat (8) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flag("reset irq", 1'b0, timer_irq_o);
        check_flag("reset hold", HoldDisable, hold_flag_o);

        for (int i = 0; i < NumRam; i++) begin
            word = int'($urandom_range(249));
            data = $urandom;
            m0_write("ram write", RegionRam, word, data);
            ram_m[word] = data;
            ram_words.push_back(word);
        end
        foreach (ram_words[i]) begin
            if (i % 2 == 0) begin
                m0_read("ram read m0", RegionRam, ram_words[i]);
            end else begin
                m1_read("ram read m1", ram_words[i]);
            end
        end

        for (int w = 250; w < 254; w++) begin  // known contents for the contention words
            data = $urandom;
            m0_write("arb setup", RegionRam, w, data);
            ram_m[w] = data;
        end
        data = $urandom;
        @(posedge clk_i);
        m3_addr_i <= make_addr(RegionRam, 250);
        m3_data_i <= data;
        {m3_we_i, m3_req_i} <= 2'b11;
        m0_addr_i <= make_addr(RegionRam, 251);
        m0_data_i <= ~data;
        {m0_we_i, m0_req_i} <= 2'b11;
        @(negedge clk_i);
        check_flag("arb m0 ready", 1'b0, m0_ready_o);
        check_word("arb m0 data", '0, m0_data_o);
        check_word("arb m3 data", expected_read(RegionRam, 250, gpio_i), m3_data_o);
        check_flag("arb m3 hold", HoldEnable, hold_flag_o);
        @(posedge clk_i);
        {m3_req_i, m3_we_i, m0_req_i, m0_we_i} <= '0;
        ram_m[250] = data;
        data = $urandom;
        @(posedge clk_i);
        m2_addr_i <= make_addr(RegionRam, 252);
        m2_data_i <= data;
        {m2_we_i, m2_req_i} <= 2'b11;
        m1_addr_i <= make_addr(RegionRam, 253);
        m1_data_i <= ~data;
        {m1_we_i, m1_req_i} <= 2'b11;
        @(negedge clk_i);
        check_flag("arb m1 ready", 1'b0, m1_ready_o);
        check_word("arb m1 data", INST_NOP, m1_data_o);
        check_word("arb m2 data", expected_read(RegionRam, 252, gpio_i), m2_data_o);
        check_flag("arb m2 hold", HoldEnable, hold_flag_o);
        @(posedge clk_i);
        {m2_req_i, m2_we_i, m1_req_i, m1_we_i} <= '0;
        ram_m[252] = data;
        for (int w = 250; w < 254; w++) begin
            m0_read("arb read back", RegionRam, w);
        end

        for (int i = 0; i < NumGpio; i++) begin
            data = $urandom;
            m0_write("gpio out write", RegionGpio, GpioOffOut, data);
            out_m = data[GpioWidth-1:0];
            data = $urandom;
            m0_write("gpio dir write", RegionGpio, GpioOffDir, data);
            dir_m = data[GpioWidth-1:0];
            @(posedge clk_i);
            gpio_i <= GpioWidth'($urandom);
            m0_read("gpio out read", RegionGpio, GpioOffOut);
            m0_read("gpio dir read", RegionGpio, GpioOffDir);
            m0_read("gpio pin read", RegionGpio, GpioOffPin);
        end

        for (int i = 0; i < NumWait; i++) begin
            word = int'($urandom_range(2**WaitDepthLog2 - 1));
            data = $urandom;
            m0_write("wait write", RegionWait, word, data);
            wait_m[word] = data;
            wait_words.push_back(word);
        end
        foreach (wait_words[i]) begin
            m0_read("wait read", RegionWait, wait_words[i]);
        end

        data = $urandom;
        m0_write("timer value write", RegionTimer, TimerOffValue, data);
        value_m = data;
        m0_read("timer value read", RegionTimer, TimerOffValue);
        c_val = int'($urandom_range(20, 4));
        m2_write(make_addr(RegionTimer, TimerOffCmp), MemBus'(c_val));
        cmp_m = MemBus'(c_val);
        m0_read("timer cmp read", RegionTimer, TimerOffCmp);
        check_flag("irq while disabled", 1'b0, timer_irq_o);
        m2_write(make_addr(RegionTimer, TimerOffCtrl), 32'd1);  // enable, value restarts
        en_m   = 1'b1;
        cycles = 0;
        @(negedge clk_i);
        while (!timer_irq_o && cycles < c_val + 8) begin
            cycles++;
            @(negedge clk_i);
        end
        check_word("timer irq delay", MemBus'(c_val), MemBus'(cycles));
        m2_write(make_addr(RegionTimer, TimerOffCtrl), 32'd0);
        en_m = 1'b0;
        @(negedge clk_i);
        check_flag("irq after disable", 1'b0, timer_irq_o);
        m0_read("timer ctrl read", RegionTimer, TimerOffCtrl);
        m0_read("unmapped read", 4'h9, int'($urandom_range(1023)));

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- flist.f
logic/soc_bus_pkg.sv
logic/rib.sv
logic/data_ram.sv
logic/gpio_regs.sv
logic/machine_timer.sv
logic/wait_ram.sv
logic/soc_bus_top.sv
verification/soc_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the bus subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module soc_bus_tb -f flist.f -Mdir obj_dir -o soc_bus_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/soc_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
